/* rtl/heap_pkg.sv */
// heap manager shared definitions
package heap_pkg;

    // word sizes
    localparam int DATA_SZ = 16;                                // data word and tagged address
    localparam int ADDR_SZ = 8;                                 // cell offset, 256 cells

    // type-tags
    localparam logic [DATA_SZ-1:0] DIR_TAG = 16'h8000;          // direct (fixnum) value
    localparam logic [DATA_SZ-1:0] MUT_TAG = 16'h4000;          // mutable
    localparam logic [DATA_SZ-1:0] OPQ_TAG = 16'h2000;          // opaque capability
    localparam logic [DATA_SZ-1:0] VLT_TAG = 16'h1000;          // volatile

    // reserved constants
    localparam logic [DATA_SZ-1:0] UNDEF = 16'h0000;            // undefined, free/write result
    localparam logic [DATA_SZ-1:0] NIL   = 16'h0001;            // end of free list

    // first heap cell, mutable and volatile, direct clear
    localparam logic [DATA_SZ-1:0] HEAP_BASE = MUT_TAG | VLT_TAG;

    // response slots, buffered plus in flight
    localparam int RSP_DEPTH = 4;

    typedef enum logic [2:0] {
        OP_ALLOC      = 3'd0,                                   // fresh or free-list cell
        OP_FREE       = 3'd1,                                   // link cell into free list
        OP_ALLOC_FREE = 3'd2,                                   // reuse the given cell
        OP_WRITE      = 3'd3,
        OP_READ       = 3'd4
    } heap_op_e;                                                // codes 5..7 illegal

endpackage

/* rtl/heap_cmd_decode.sv */
// heap command decode stage
module heap_cmd_decode (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_cmd_valid,          // host command valid
    output logic                          o_cmd_ready,          // decode can take it
    input  heap_pkg::heap_op_e            i_cmd_op,
    input  logic [heap_pkg::DATA_SZ-1:0]  i_cmd_addr,           // tagged address
    input  logic [heap_pkg::DATA_SZ-1:0]  i_cmd_data,
    input  logic                          i_slot_avail,         // response credit free
    input  logic                          i_halt,               // sticky error
    output logic                          o_accept,             // credit pulse to result
    output logic                          o_alloc,              // alloc or alloc-with-free
    output logic                          o_free,
    output logic                          o_wr,
    output logic                          o_rd,
    output heap_pkg::heap_op_e            o_op,
    output logic [heap_pkg::DATA_SZ-1:0]  o_addr,
    output logic [heap_pkg::DATA_SZ-1:0]  o_data,
    output logic                          o_bad                 // command failed its check
);

    logic r_live;                                               // first edge after reset seen
    logic legal;                                                // known opcode
    logic ptr_ok;                                               // heap tags in upper byte
    logic bad;

    assign o_cmd_ready = r_live & i_slot_avail & ~i_halt;
    assign o_accept    = i_cmd_valid & o_cmd_ready;

    assign legal  = i_cmd_op inside {heap_pkg::OP_ALLOC, heap_pkg::OP_FREE,
                                     heap_pkg::OP_ALLOC_FREE, heap_pkg::OP_WRITE,
                                     heap_pkg::OP_READ};
    assign ptr_ok = i_cmd_addr[heap_pkg::DATA_SZ-1:heap_pkg::ADDR_SZ] ==
                    heap_pkg::HEAP_BASE[heap_pkg::DATA_SZ-1:heap_pkg::ADDR_SZ];
    // plain alloc carries no address
    assign bad    = ~legal | ((i_cmd_op != heap_pkg::OP_ALLOC) & ~ptr_ok);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_live  <= 1'b0;
            o_alloc <= 1'b0;
            o_free  <= 1'b0;
            o_wr    <= 1'b0;
            o_rd    <= 1'b0;
            o_bad   <= 1'b0;
        end else begin
            r_live  <= 1'b1;
            o_alloc <= o_accept & ~bad & ((i_cmd_op == heap_pkg::OP_ALLOC) |
                                          (i_cmd_op == heap_pkg::OP_ALLOC_FREE));
            o_free  <= o_accept & ~bad & (i_cmd_op == heap_pkg::OP_FREE);
            o_wr    <= o_accept & ~bad & (i_cmd_op == heap_pkg::OP_WRITE);
            o_rd    <= o_accept & ~bad & (i_cmd_op == heap_pkg::OP_READ);
            o_bad   <= o_accept & bad;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_accept) begin                                     // payload, held with strobes
            o_op   <= i_cmd_op;
            o_addr <= i_cmd_addr;
            o_data <= i_cmd_data;
        end
    end

    // execute sees a single request per cycle
    a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0({o_alloc, o_free, o_wr, o_rd, o_bad}));

endmodule

/* rtl/heap_alloc.sv */
// heap execute stage, linked free-list allocator
module heap_alloc (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_alloc,              // alloc or alloc-with-free
    input  logic                          i_free,
    input  logic                          i_wr,
    input  logic                          i_rd,
    input  heap_pkg::heap_op_e            i_op,
    input  logic [heap_pkg::DATA_SZ-1:0]  i_addr,
    input  logic [heap_pkg::DATA_SZ-1:0]  i_data,
    input  logic                          i_bad,                // rejected by decode
    output logic                          o_ram_we,
    output logic [heap_pkg::ADDR_SZ-1:0]  o_ram_waddr,
    output logic [heap_pkg::DATA_SZ-1:0]  o_ram_wdata,
    output logic                          o_ram_re,
    output logic [heap_pkg::ADDR_SZ-1:0]  o_ram_raddr,
    input  logic [heap_pkg::DATA_SZ-1:0]  i_ram_rdata,          // one cycle after o_ram_re
    output logic                          o_done,               // response ready
    output heap_pkg::heap_op_e            o_op,
    output logic [heap_pkg::DATA_SZ-1:0]  o_data,
    output logic                          o_err                 // sticky halt
);

    logic [heap_pkg::DATA_SZ-1:0] r_top;                        // next fresh cell
    logic [heap_pkg::DATA_SZ-1:0] r_head;                       // free-list head, NIL if empty
    logic [heap_pkg::DATA_SZ-1:0] r_link;                       // shadow of cell at head
    logic                         r_link_pend;                  // link is on ram output now
    logic                         r_rd;                         // read result on ram output
    logic [heap_pkg::DATA_SZ-1:0] r_data;                       // alloc address or UNDEF
    logic [heap_pkg::DATA_SZ-1:0] link_w;                       // current link of head
    logic                         live;
    logic                         reuse;                        // alloc-with-free
    logic                         from_list;
    logic                         from_top;
    logic                         oom;                          // top exhausted, list empty

    assign live      = ~o_err;
    assign link_w    = r_link_pend ? i_ram_rdata : r_link;
    assign reuse     = i_alloc & (i_op == heap_pkg::OP_ALLOC_FREE);
    assign from_list = i_alloc & ~reuse & (r_head != heap_pkg::NIL);
    assign from_top  = i_alloc & ~reuse & (r_head == heap_pkg::NIL);
    assign oom       = from_top & (&r_top[heap_pkg::ADDR_SZ-1:0]);   // offset 255 held back

    always_comb begin
        o_ram_we    = live & ((i_alloc & ~oom) | i_free | i_wr);
        o_ram_waddr = i_addr[heap_pkg::ADDR_SZ-1:0];            // free, reuse, write
        o_ram_wdata = i_data;                                   // initial or written word
        if (from_list) begin
            o_ram_waddr = r_head[heap_pkg::ADDR_SZ-1:0];
        end else if (from_top) begin
            o_ram_waddr = r_top[heap_pkg::ADDR_SZ-1:0];
        end
        if (i_free) begin
            o_ram_wdata = r_head;                               // link old head into cell
        end
    end

    // list alloc fetches the next link on the read port
    assign o_ram_re    = live & (i_rd | from_list);
    assign o_ram_raddr = from_list ? link_w[heap_pkg::ADDR_SZ-1:0]
                                   : i_addr[heap_pkg::ADDR_SZ-1:0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_top       <= heap_pkg::HEAP_BASE;
            r_head      <= heap_pkg::NIL;
            r_link      <= heap_pkg::NIL;
            r_link_pend <= 1'b0;
            o_done      <= 1'b0;
            o_err       <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (live) begin
                r_link      <= link_w;                          // settle a pending fetch
                r_link_pend <= 1'b0;
                if (i_bad | oom) begin
                    o_err <= 1'b1;                              // no response for this one
                end else begin
                    o_done <= i_alloc | i_free | i_wr | i_rd;
                end
                if (from_list) begin
                    r_head      <= link_w;                      // pop
                    r_link_pend <= 1'b1;
                end
                if (from_top & ~oom) begin
                    r_top <= r_top + 1'b1;                      // low byte < ff, tags kept
                end
                if (i_free) begin
                    r_head <= i_addr;                           // push
                    r_link <= r_head;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_op <= i_op;
        r_rd <= i_rd;
        if (reuse) begin
            r_data <= i_addr;
        end else if (from_list) begin
            r_data <= r_head;
        end else if (from_top) begin
            r_data <= r_top;
        end else begin
            r_data <= heap_pkg::UNDEF;                          // free and write
        end
    end

    assign o_data = r_rd ? i_ram_rdata : r_data;

    a_err_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_err |=> o_err);

endmodule

/* rtl/heap_cell_ram.sv */
// heap cell memory
module heap_cell_ram (
    input  logic                          i_clk,
    input  logic                          i_we,
    input  logic [heap_pkg::ADDR_SZ-1:0]  i_waddr,
    input  logic [heap_pkg::DATA_SZ-1:0]  i_wdata,
    input  logic                          i_re,
    input  logic [heap_pkg::ADDR_SZ-1:0]  i_raddr,
    output logic [heap_pkg::DATA_SZ-1:0]  o_rdata               // registered, held when idle
);

    logic [heap_pkg::DATA_SZ-1:0] mem [0:(1 << heap_pkg::ADDR_SZ)-1];   // 256 x 16

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        if (i_re) begin
            o_rdata <= mem[i_raddr];                            // old data on same-edge write
        end
    end

endmodule

/* rtl/heap_result.sv */
// heap response queue
module heap_result (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_accept,             // command taken, one credit
    input  logic                          i_done,               // response from execute
    input  logic                          i_halt,
    input  heap_pkg::heap_op_e            i_op,
    input  logic [heap_pkg::DATA_SZ-1:0]  i_data,
    output logic                          o_slot_avail,
    output logic                          o_rsp_valid,
    input  logic                          i_rsp_ready,
    output heap_pkg::heap_op_e            o_rsp_op,
    output logic [heap_pkg::DATA_SZ-1:0]  o_rsp_data
);

    heap_pkg::heap_op_e                     r_op_q   [heap_pkg::RSP_DEPTH];
    logic [heap_pkg::DATA_SZ-1:0]           r_data_q [heap_pkg::RSP_DEPTH];
    logic [$clog2(heap_pkg::RSP_DEPTH)-1:0] r_wr_ptr;
    logic [$clog2(heap_pkg::RSP_DEPTH)-1:0] r_rd_ptr;
    logic [$clog2(heap_pkg::RSP_DEPTH):0]   r_cnt;              // buffered entries
    logic [$clog2(heap_pkg::RSP_DEPTH):0]   r_credit;           // buffered plus in flight
    logic [$clog2(heap_pkg::RSP_DEPTH):0]   credit_nx;
    logic                                   r_halted;
    logic                                   empty;
    logic                                   pop;                // handshake on output
    logic                                   push;
    logic                                   fifo_pop;

    assign empty        = (r_cnt == '0);
    assign o_rsp_valid  = ~empty | i_done;                      // empty queue passes through
    assign o_rsp_op     = empty ? i_op   : r_op_q[r_rd_ptr];
    assign o_rsp_data   = empty ? i_data : r_data_q[r_rd_ptr];
    assign pop          = o_rsp_valid & i_rsp_ready;
    assign push         = i_done & ~(empty & i_rsp_ready);
    assign fifo_pop     = pop & ~empty;
    assign o_slot_avail = (r_credit < heap_pkg::RSP_DEPTH);

    always_comb begin
        credit_nx = r_credit;
        if (i_accept) credit_nx = credit_nx + 1'b1;
        if (pop) credit_nx = credit_nx - 1'b1;
        if (i_halt & ~r_halted) credit_nx = credit_nx - 1'b1;  // failing cmd never answers
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_cnt    <= '0;
            r_credit <= '0;
            r_halted <= 1'b0;
        end else begin
            r_credit <= credit_nx;
            r_halted <= i_halt;
            if (push) r_wr_ptr <= r_wr_ptr + 1'b1;
            if (fifo_pop) r_rd_ptr <= r_rd_ptr + 1'b1;
            if (push & ~fifo_pop) r_cnt <= r_cnt + 1'b1;
            else if (fifo_pop & ~push) r_cnt <= r_cnt - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            r_op_q[r_wr_ptr]   <= i_op;
            r_data_q[r_wr_ptr] <= i_data;
        end
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        push |-> (r_cnt < heap_pkg::RSP_DEPTH));
    a_rsp_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_rsp_valid & ~i_rsp_ready) |=>
            (o_rsp_valid & $stable(o_rsp_op) & $stable(o_rsp_data)));

endmodule

/* rtl/heap_top.sv */
// tagged-pointer heap manager
module heap_top (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_cmd_valid,
    output logic                          o_cmd_ready,
    input  heap_pkg::heap_op_e            i_cmd_op,
    input  logic [heap_pkg::DATA_SZ-1:0]  i_cmd_addr,
    input  logic [heap_pkg::DATA_SZ-1:0]  i_cmd_data,
    output logic                          o_rsp_valid,
    input  logic                          i_rsp_ready,
    output heap_pkg::heap_op_e            o_rsp_op,
    output logic [heap_pkg::DATA_SZ-1:0]  o_rsp_data,
    output logic                          o_err                 // sticky, halts everything
);

    // decode to execute
    logic                         s_accept, s_alloc, s_free, s_wr, s_rd, s_bad;
    heap_pkg::heap_op_e           s_op;
    logic [heap_pkg::DATA_SZ-1:0] s_addr, s_data;
    // execute to cell ram
    logic                         m_we, m_re;
    logic [heap_pkg::ADDR_SZ-1:0] m_waddr, m_raddr;
    logic [heap_pkg::DATA_SZ-1:0] m_wdata, m_rdata;
    // execute to result
    logic                         x_done;
    heap_pkg::heap_op_e           x_op;
    logic [heap_pkg::DATA_SZ-1:0] x_data;
    logic                         slot_avail;                   // credit back to decode

    heap_cmd_decode u_decode (
        .i_clk, .i_rst_n, .i_cmd_valid, .o_cmd_ready, .i_cmd_op, .i_cmd_addr, .i_cmd_data,
        .i_slot_avail(slot_avail), .i_halt(o_err), .o_accept(s_accept),
        .o_alloc(s_alloc), .o_free(s_free), .o_wr(s_wr), .o_rd(s_rd),
        .o_op(s_op), .o_addr(s_addr), .o_data(s_data), .o_bad(s_bad)
    );

    heap_alloc u_alloc (
        .i_clk, .i_rst_n, .i_alloc(s_alloc), .i_free(s_free), .i_wr(s_wr), .i_rd(s_rd),
        .i_op(s_op), .i_addr(s_addr), .i_data(s_data), .i_bad(s_bad),
        .o_ram_we(m_we), .o_ram_waddr(m_waddr), .o_ram_wdata(m_wdata),
        .o_ram_re(m_re), .o_ram_raddr(m_raddr), .i_ram_rdata(m_rdata),
        .o_done(x_done), .o_op(x_op), .o_data(x_data), .o_err
    );

    heap_cell_ram u_ram (
        .i_clk, .i_we(m_we), .i_waddr(m_waddr), .i_wdata(m_wdata),
        .i_re(m_re), .i_raddr(m_raddr), .o_rdata(m_rdata)
    );

    heap_result u_result (
        .i_clk, .i_rst_n, .i_accept(s_accept), .i_done(x_done), .i_halt(o_err),
        .i_op(x_op), .i_data(x_data), .o_slot_avail(slot_avail),
        .o_rsp_valid, .i_rsp_ready, .o_rsp_op, .o_rsp_data
    );

endmodule

/* tests/heap_tb.sv */
// heap manager testbench
module heap_tb;

    logic                          i_clk;
    logic                          i_rst_n;
    logic                          i_cmd_valid;
    logic                          o_cmd_ready;
    heap_pkg::heap_op_e            i_cmd_op;
    logic [heap_pkg::DATA_SZ-1:0]  i_cmd_addr;
    logic [heap_pkg::DATA_SZ-1:0]  i_cmd_data;
    logic                          o_rsp_valid;
    logic                          i_rsp_ready;
    heap_pkg::heap_op_e            o_rsp_op;
    logic [heap_pkg::DATA_SZ-1:0]  o_rsp_data;
    logic                          o_err;

    // command and expectation table, one entry per command
    int                            t_phase    [$];          // reset group
    logic [2:0]                    t_op       [$];
    logic [heap_pkg::DATA_SZ-1:0]  t_addr     [$];
    logic [heap_pkg::DATA_SZ-1:0]  t_data     [$];
    logic                          t_rsp      [$];          // response expected
    logic [2:0]                    t_exp_op   [$];
    logic [heap_pkg::DATA_SZ-1:0]  t_exp_data [$];

    int                            cycle_cnt   = 0;
    int                            cycle_limit = 0;
    integer                        seed        = 32'h2f1a;
    integer                        rnd;

    heap_top DUT (
        .i_clk, .i_rst_n, .i_cmd_valid, .o_cmd_ready, .i_cmd_op, .i_cmd_addr, .i_cmd_data,
        .o_rsp_valid, .i_rsp_ready, .o_rsp_op, .o_rsp_data, .o_err
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "heap_tb stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic add_cmd(input int phase, input logic [2:0] op, input logic [15:0] addr,
                           input logic [15:0] data, input logic rsp,
                           input logic [15:0] exp_data);
        t_phase.push_back(phase);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_rsp.push_back(rsp);
        t_exp_op.push_back(op);                                  // response echoes opcode
        t_exp_data.push_back(exp_data);
    endtask

    task automatic build_table();
        int k;
        for (k = 0; k < 4; k++) begin                            // fresh cells in order
            add_cmd(0, heap_pkg::OP_ALLOC, 16'h0, 16'h0a00 + k, 1'b1, heap_pkg::HEAP_BASE + k);
        end
        for (k = 0; k < 4; k++) begin                            // initial data back
            add_cmd(0, heap_pkg::OP_READ, heap_pkg::HEAP_BASE + k, 16'h0, 1'b1, 16'h0a00 + k);
        end
        add_cmd(0, heap_pkg::OP_WRITE, 16'h5001, 16'hbeef, 1'b1, heap_pkg::UNDEF);
        add_cmd(0, heap_pkg::OP_READ, 16'h5001, 16'h0, 1'b1, 16'hbeef);
        add_cmd(0, heap_pkg::OP_FREE, 16'h5000, 16'h0, 1'b1, heap_pkg::UNDEF);      // A
        add_cmd(0, heap_pkg::OP_FREE, 16'h5002, 16'h0, 1'b1, heap_pkg::UNDEF);      // B
        add_cmd(0, heap_pkg::OP_ALLOC, 16'h0, 16'h0b01, 1'b1, 16'h5002);            // LIFO, B first
        add_cmd(0, heap_pkg::OP_ALLOC, 16'h0, 16'h0b02, 1'b1, 16'h5000);
        add_cmd(0, heap_pkg::OP_READ, 16'h5002, 16'h0, 1'b1, 16'h0b01);
        add_cmd(0, heap_pkg::OP_READ, 16'h5000, 16'h0, 1'b1, 16'h0b02);
        add_cmd(0, heap_pkg::OP_ALLOC_FREE, 16'h5003, 16'h0c33, 1'b1, 16'h5003);    // reuse C
        add_cmd(0, heap_pkg::OP_READ, 16'h5003, 16'h0, 1'b1, 16'h0c33);
        add_cmd(0, heap_pkg::OP_ALLOC, 16'h0, 16'h0a55, 1'b1, 16'h5004);            // top unmoved
        add_cmd(0, heap_pkg::OP_READ, 16'h5004, 16'h0, 1'b1, 16'h0a55);
        add_cmd(0, heap_pkg::OP_FREE, 16'h5001, 16'h0, 1'b1, heap_pkg::UNDEF);
        add_cmd(0, heap_pkg::OP_ALLOC, 16'h0, 16'h0d01, 1'b1, 16'h5001);            // back to back
        add_cmd(0, heap_pkg::OP_READ, 16'h5001, 16'h0, 1'b1, 16'h0d01);
        for (k = 0; k < 8; k++) begin                            // burst under back-pressure
            add_cmd(0, heap_pkg::OP_ALLOC, 16'h0, 16'h2000 + k, 1'b1, 16'h5005 + k);
        end
        for (k = 0; k < 8; k++) begin
            add_cmd(0, heap_pkg::OP_READ, 16'h5005 + k, 16'h0, 1'b1, 16'h2000 + k);
        end
        // illegal opcode after two good ones
        add_cmd(1, heap_pkg::OP_ALLOC, 16'h0, 16'h0e01, 1'b1, 16'h5000);
        add_cmd(1, heap_pkg::OP_READ, 16'h5000, 16'h0, 1'b1, 16'h0e01);
        add_cmd(1, 3'd6, 16'h5000, 16'h0, 1'b0, 16'h0);                             // no answer
        // wrong tags on a read
        add_cmd(2, heap_pkg::OP_ALLOC, 16'h0, 16'h0e02, 1'b1, 16'h5000);
        add_cmd(2, heap_pkg::OP_WRITE, 16'h5000, 16'h0f0f, 1'b1, heap_pkg::UNDEF);
        add_cmd(2, heap_pkg::OP_READ, 16'h1234, 16'h0, 1'b0, 16'h0);                // no answer
        // exhaustion, offsets 0..254 then failure
        for (k = 0; k < 255; k++) begin
            add_cmd(3, heap_pkg::OP_ALLOC, 16'h0, 16'h3000 + k, 1'b1, heap_pkg::HEAP_BASE + k);
        end
        add_cmd(3, heap_pkg::OP_ALLOC, 16'h0, 16'h30ff, 1'b0, 16'h0);               // no answer
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst_n     = 1'b0;
        i_cmd_valid = 1'b0;
        repeat (2) @(negedge i_clk);                             // two cycles low
        i_rst_n = 1'b1;
    endtask

    task automatic send_commands(input int phase);
        int i;
        for (i = 0; i < t_op.size(); i++) begin
            if (t_phase[i] == phase) begin
                @(negedge i_clk);
                i_cmd_valid = 1'b1;
                i_cmd_op    = heap_pkg::heap_op_e'(t_op[i]);     // illegal codes pass too
                i_cmd_addr  = t_addr[i];
                i_cmd_data  = t_data[i];
                @(posedge i_clk);
                while (!o_cmd_ready) begin                       // held until taken
                    @(posedge i_clk);
                end
            end
        end
        @(negedge i_clk);
        i_cmd_valid = 1'b0;
    endtask

    task automatic collect_responses(input int phase);
        int i;
        for (i = 0; i < t_op.size(); i++) begin
            if (t_phase[i] == phase && t_rsp[i]) begin
                @(posedge i_clk);
                while (!(o_rsp_valid && i_rsp_ready)) begin
                    @(posedge i_clk);
                end
                check_value("o_rsp_op", o_rsp_op, t_exp_op[i]);      // strict command order
                check_value("o_rsp_data", o_rsp_data, t_exp_data[i]);
            end
        end
    endtask

    task automatic check_halt();
        repeat (8) begin                                         // err may still be in flight
            @(posedge i_clk);
            if (o_rsp_valid) begin
                $display("a response came back for the command that raised the error");
                abort_run();
            end
        end
        check_value("o_err", o_err, 16'h1);
        check_value("o_cmd_ready", o_cmd_ready, 16'h0);
    endtask

    // random back-pressure, about half the cycles stalled
    initial begin
        forever begin
            @(negedge i_clk);
            rnd         = $random(seed);
            i_rsp_ready = rnd[0];
        end
    end

    initial begin
        forever begin
            @(posedge i_clk);
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                $display("timeout after %0d cycles, the DUT stopped making progress",
                         cycle_cnt);
                abort_run();
            end
        end
    end

    initial begin
        int p;
        i_rst_n     = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd_op    = heap_pkg::OP_ALLOC;
        i_cmd_addr  = '0;
        i_cmd_data  = '0;
        i_rsp_ready = 1'b0;
        build_table();
        cycle_limit = 20 * t_op.size() + 600;
        for (p = 0; p < 4; p++) begin                            // normal, bad op, bad tag, oom
            apply_reset();
            fork
                send_commands(p);
                collect_responses(p);
            join
            if (p == 0) begin
                check_value("o_err", o_err, 16'h0);
            end else begin
                check_halt();
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* compile.f */
rtl/heap_pkg.sv
rtl/heap_cmd_decode.sv
rtl/heap_alloc.sv
rtl/heap_cell_ram.sv
rtl/heap_result.sv
rtl/heap_top.sv
tests/heap_tb.sv
